/* source/cachePkg.sv */
package cachePkg;

  // Cache geometry
  localparam int dataWidth    = 32;
  localparam int tagWidth     = 20;
  localparam int indexWidth   = 7;
  localparam int wordSelWidth = 3;
  localparam int numWays      = 4;
  localparam int lineWidth    = 256;
  localparam int numSets      = 128;

  typedef struct packed {
    logic [tagWidth-1:0]     tag;
    logic [indexWidth-1:0]   index;
    logic [wordSelWidth-1:0] wordSel;
    logic [1:0]              byteOff;
  } addrFields;

  // Same request address, raw from the port or split into its fields
  typedef union packed {
    logic [31:0] raw;
    addrFields   fields;
  } cacheAddr;

  typedef logic [1:0] wayId;

  // 3 is most recent, 0 is the replacement candidate
  typedef logic [1:0] age;
  typedef age [numWays-1:0] setAges;

  typedef logic [2**wordSelWidth-1:0][dataWidth-1:0] cacheLine;

endpackage

/* source/wayIf.sv */
`timescale 1ns/10ps

interface wayIf import cachePkg::*; ();

  // Lookup request, sampled by the way at the request edge
  logic                  lookup;
  logic [indexWidth-1:0] index;
  logic [tagWidth-1:0]   tag;

  // Lookup result, valid in the cycle after the lookup
  logic                  hit;
  logic                  valid;
  cacheLine              line;

  // Update of the looked-up set; fill also loads tag and valid
  logic                  write;
  cacheLine              writeLine;
  logic                  fill;

  modport way (
    input  lookup, index, tag, write, writeLine, fill,
    output hit, valid, line
  );

  modport ctrl (
    output lookup, index, tag, write, writeLine, fill,
    input  hit, valid, line
  );

endinterface

/* source/syncRam.sv */
`timescale 1ns/10ps

module syncRam #(
  parameter int depth = 128,
  parameter int width = 32
) (
  input  logic                     clk,
  input  logic                     en,
  input  logic                     wr,
  input  logic [$clog2(depth)-1:0] addr,
  input  logic [$clog2(depth)-1:0] wrAddr,
  input  logic [width-1:0]         wrData,
  output logic [width-1:0]         rdData
);

  logic [width-1:0] mem [depth];

  // Write of the previous request can share the edge with the next lookup
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wrAddr] <= wrData;
    end
    if (en) begin
      rdData <= (wr && (wrAddr == addr)) ? wrData : mem[addr];
    end
  end

endmodule

/* source/cacheWay.sv */
`timescale 1ns/10ps

module cacheWay import cachePkg::*; (
  input logic clk,
  input logic resetn,
  wayIf.way   bus
);

  logic [numSets-1:0]    validBits;
  logic                  regValid;
  logic [indexWidth-1:0] regIndex;
  logic [tagWidth-1:0]   regTag;
  logic [tagWidth-1:0]   storedTag;

  syncRam #(
    .depth (numSets),
    .width (lineWidth)
  ) dataRam (
    .clk    (clk),
    .en     (bus.lookup),
    .wr     (bus.write),
    .addr   (bus.index),
    .wrAddr (regIndex),
    .wrData (bus.writeLine),
    .rdData (bus.line)
  );

  syncRam #(
    .depth (numSets),
    .width (tagWidth)
  ) tagRam (
    .clk    (clk),
    .en     (bus.lookup),
    .wr     (bus.fill),
    .addr   (bus.index),
    .wrAddr (regIndex),
    .wrData (regTag),
    .rdData (storedTag)
  );

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      validBits <= '0;
      regValid  <= 1'b0;
    end else begin
      if (bus.fill) begin
        validBits[regIndex] <= 1'b1;
      end
      if (bus.lookup) begin
        regValid <= validBits[bus.index];
      end
    end
  end

  // Index and tag are kept for the compare and for the later write
  always_ff @(posedge clk) begin
    if (bus.lookup) begin
      regIndex <= bus.index;
      regTag   <= bus.tag;
    end
  end

  assign bus.valid = regValid;
  assign bus.hit   = regValid && (storedTag == regTag);

endmodule

/* source/lruAges.sv */
`timescale 1ns/10ps

module lruAges import cachePkg::*; (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic [indexWidth-1:0] index,
  input  logic                  update,
  input  wayId                  accessWay,
  output setAges                ages
);

  setAges ageTable [numSets];
  setAges nextAges;
  age     oldAge;

  assign ages = ageTable[index];

  // Accessed way becomes most recent, younger ways shift down by one
  always_comb begin
    oldAge = ages[accessWay];
    for (int w = 0; w < numWays; w++) begin
      if (wayId'(w) == accessWay) begin
        nextAges[w] = 2'd3;
      end else if (ages[w] > oldAge) begin
        nextAges[w] = ages[w] - 2'd1;
      end else begin
        nextAges[w] = ages[w];
      end
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int s = 0; s < numSets; s++) begin
        for (int w = 0; w < numWays; w++) begin
          ageTable[s][w] <= age'(w);
        end
      end
    end else if (update) begin
      ageTable[index] <= nextAges;
    end
  end

endmodule

/* source/accessControl.sv */
`timescale 1ns/10ps

module accessControl import cachePkg::*; (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  rd,
  input  logic                  wr,
  input  cacheAddr              addr,
  input  logic [dataWidth-1:0]  wrData,
  wayIf.ctrl                    ways [numWays],
  input  setAges                ages,
  output logic [indexWidth-1:0] lruIndex,
  output logic                  lruUpdate,
  output wayId                  lruWay,
  output logic [dataWidth-1:0]  rdData,
  output logic                  ready,
  output logic                  hit
);

  logic                    reqRd;
  logic                    reqWr;
  logic [indexWidth-1:0]   reqIndex;
  logic [wordSelWidth-1:0] reqWordSel;
  logic [dataWidth-1:0]    reqData;
  logic [numWays-1:0]      wayHit;
  logic [numWays-1:0]      wayValid;
  cacheLine                wayLine [numWays];
  logic                    anyHit;
  wayId                    hitWay;
  wayId                    victimWay;
  wayId                    selWay;
  cacheLine                hitLine;
  cacheLine                newLine;

  genvar i;
  generate
    for (i = 0; i < numWays; i++) begin : gWay
      assign ways[i].lookup    = rd | wr;
      assign ways[i].index     = addr.fields.index;
      assign ways[i].tag       = addr.fields.tag;
      assign ways[i].write     = reqWr && (selWay == wayId'(i));
      assign ways[i].fill      = reqWr && !anyHit && (selWay == wayId'(i));
      assign ways[i].writeLine = newLine;
      assign wayHit[i]         = ways[i].hit;
      assign wayValid[i]       = ways[i].valid;
      assign wayLine[i]        = ways[i].line;
    end
  endgenerate

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      reqRd <= 1'b0;
      reqWr <= 1'b0;
    end else begin
      reqRd <= rd;
      reqWr <= wr;
    end
  end

  always_ff @(posedge clk) begin
    if (rd | wr) begin
      reqIndex   <= addr.fields.index;
      reqWordSel <= addr.fields.wordSel;
      reqData    <= wrData;
    end
  end

  always_comb begin
    hitWay = '0;
    for (int w = numWays - 1; w >= 0; w--) begin
      if (wayHit[w]) begin
        hitWay = wayId'(w);
      end
    end
    // Oldest way, overridden by the lowest invalid way
    victimWay = '0;
    for (int w = numWays - 1; w >= 0; w--) begin
      if (ages[w] == '0) begin
        victimWay = wayId'(w);
      end
    end
    for (int w = numWays - 1; w >= 0; w--) begin
      if (!wayValid[w]) begin
        victimWay = wayId'(w);
      end
    end
  end

  assign anyHit  = |wayHit;
  assign selWay  = anyHit ? hitWay : victimWay;
  assign hitLine = wayLine[hitWay];

  // Merge into the hit line, or start a fresh zero line on allocation
  always_comb begin
    newLine             = anyHit ? hitLine : '0;
    newLine[reqWordSel] = reqData;
  end

  assign lruIndex  = reqIndex;
  assign lruWay    = selWay;
  assign lruUpdate = (reqRd && anyHit) || reqWr;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      ready  <= 1'b0;
      hit    <= 1'b0;
      rdData <= '0;
    end else begin
      ready  <= reqRd | reqWr;
      hit    <= (reqRd | reqWr) && anyHit;
      rdData <= (reqRd && anyHit) ? hitLine[reqWordSel] : '0;
    end
  end

endmodule

/* source/cacheTop.sv */
`timescale 1ns/10ps

module cacheTop import cachePkg::*; (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 iRd,
  input  logic                 iWr,
  input  logic [dataWidth-1:0] iData,
  input  logic [31:0]          iAddr,
  output logic [dataWidth-1:0] oData,
  output logic                 oReady,
  output logic                 oHit
);

  cacheAddr              reqAddr;
  logic [indexWidth-1:0] lruIndex;
  logic                  lruUpdate;
  wayId                  lruWay;
  setAges                ages;

  wayIf ways [numWays] ();

  assign reqAddr.raw = iAddr;

  genvar i;
  generate
    for (i = 0; i < numWays; i++) begin : gWay
      cacheWay way (
        .clk    (clk),
        .resetn (resetn),
        .bus    (ways[i])
      );
    end
  endgenerate

  lruAges ageTable (
    .clk       (clk),
    .resetn    (resetn),
    .index     (lruIndex),
    .update    (lruUpdate),
    .accessWay (lruWay),
    .ages      (ages)
  );

  accessControl ctrl (
    .clk       (clk),
    .resetn    (resetn),
    .rd        (iRd),
    .wr        (iWr),
    .addr      (reqAddr),
    .wrData    (iData),
    .ways      (ways),
    .ages      (ages),
    .lruIndex  (lruIndex),
    .lruUpdate (lruUpdate),
    .lruWay    (lruWay),
    .rdData    (oData),
    .ready     (oReady),
    .hit       (oHit)
  );

endmodule

/* dv/cacheTb.sv */
`timescale 1ns/10ps

module cacheTb import cachePkg::*; ();

  localparam int numRandom = 600;
  // Directed and random requests at up to two cycles each, plus reset and margin
  localparam int maxCycles = 5 * (numRandom + 200);

  logic                  clk;
  logic                  resetn;
  logic                  iRd;
  logic                  iWr;
  logic [dataWidth-1:0]  iData;
  logic [31:0]           iAddr;
  logic [dataWidth-1:0]  oData;
  logic                  oReady;
  logic                  oHit;

  int                    cycle;
  bit                    prevBusy;
  logic [indexWidth-1:0] prevIndex;

  // Outstanding requests, oldest first
  logic                  expHitQ [$];
  logic [dataWidth-1:0]  expDataQ [$];
  int                    expCycleQ [$];
  string                 nameQ [$];

  // Reference model of tags, valid bits, lines and ages
  logic [tagWidth-1:0]   refTag [numSets][numWays];
  bit                    refValid [numSets][numWays];
  age                    refAge [numSets][numWays];
  logic [dataWidth-1:0]  refLine [numSets][numWays][2**wordSelWidth];

  cacheTop UUT (
    .clk    (clk),
    .resetn (resetn),
    .iRd    (iRd),
    .iWr    (iWr),
    .iData  (iData),
    .iAddr  (iAddr),
    .oData  (oData),
    .oReady (oReady),
    .oHit   (oHit)
  );

  always #5 clk = ~clk;

  task automatic abortRun();
    $display("Test failed");
    $fatal(1);
  endtask

  // Read only at the falling edge and after the stimulus delay
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle == maxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", maxCycles);
      abortRun();
    end
  end

  task automatic checkHit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: oHit expected %0b, actual %0b", name, expected, actual);
      abortRun();
    end
  endtask

  task automatic checkData(input string name, input logic [dataWidth-1:0] expected,
                           input logic [dataWidth-1:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: oData expected %h, actual %h", name, expected, actual);
      abortRun();
    end
  endtask

  function automatic logic [31:0] makeAddr(input logic [tagWidth-1:0] tag,
                                           input logic [indexWidth-1:0] index,
                                           input logic [wordSelWidth-1:0] wordSel);
    cacheAddr a;
    a.fields.tag     = tag;
    a.fields.index   = index;
    a.fields.wordSel = wordSel;
    a.fields.byteOff = 2'b00;
    return a.raw;
  endfunction

  // Applies one request to the model and returns what the DUT should report
  function automatic void refAccess(input bit isWr, input cacheAddr a,
                                    input logic [dataWidth-1:0] data, output logic expHit,
                                    output logic [dataWidth-1:0] expData);
    logic [indexWidth-1:0] s;
    bit                    found;
    bit                    haveInvalid;
    wayId                  way;
    age                    oldAge;
    s           = a.fields.index;
    found       = 1'b0;
    haveInvalid = 1'b0;
    way         = '0;
    expData     = '0;
    for (int w = 0; w < numWays; w++) begin
      if (refValid[s][w] && refTag[s][w] == a.fields.tag) begin
        found = 1'b1;
        way   = wayId'(w);
      end
    end
    expHit = found;
    if (!found && isWr) begin
      // Lowest invalid way first, else the least recently used one
      for (int w = numWays - 1; w >= 0; w--) begin
        if (!refValid[s][w]) begin
          haveInvalid = 1'b1;
          way         = wayId'(w);
        end
      end
      if (!haveInvalid) begin
        for (int w = 0; w < numWays; w++) begin
          if (refAge[s][w] == 2'd0) begin
            way = wayId'(w);
          end
        end
      end
      for (int k = 0; k < 2**wordSelWidth; k++) begin
        refLine[s][way][k] = '0;
      end
      refValid[s][way] = 1'b1;
      refTag[s][way]   = a.fields.tag;
    end
    if (found || isWr) begin
      if (isWr) begin
        refLine[s][way][a.fields.wordSel] = data;
      end else begin
        expData = refLine[s][way][a.fields.wordSel];
      end
      oldAge = refAge[s][way];
      for (int w = 0; w < numWays; w++) begin
        if (wayId'(w) == way) begin
          refAge[s][w] = 2'd3;
        end else if (refAge[s][w] > oldAge) begin
          refAge[s][w] = refAge[s][w] - 2'd1;
        end
      end
    end
  endfunction

  task automatic idle(input int n);
    iRd = 1'b0;
    iWr = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
    prevBusy = 1'b0;
  endtask

  task automatic issue(input bit isWr, input logic [31:0] addr,
                       input logic [dataWidth-1:0] data, input string name);
    cacheAddr             a;
    logic                 expHit;
    logic [dataWidth-1:0] expData;
    a.raw = addr;
    // Back-to-back requests must not share a set
    if (prevBusy && a.fields.index == prevIndex) begin
      idle(1);
    end
    refAccess(isWr, a, data, expHit, expData);
    expHitQ.push_back(expHit);
    expDataQ.push_back(expData);
    expCycleQ.push_back(cycle + 2);
    nameQ.push_back(name);
    iRd   = !isWr;
    iWr   = isWr;
    iAddr = addr;
    iData = data;
    @(posedge clk);
    #1;
    iRd       = 1'b0;
    iWr       = 1'b0;
    prevBusy  = 1'b1;
    prevIndex = a.fields.index;
  endtask

  // Outputs settle after the rising edge, so compare on the falling one
  always @(negedge clk) begin
    if (oReady) begin
      if (expCycleQ.size() == 0) begin
        $display("oReady went high at cycle %0d with no request outstanding", cycle);
        abortRun();
      end else begin
        if (expCycleQ[0] != cycle) begin
          $display("oReady for %s came at cycle %0d instead of cycle %0d",
                   nameQ[0], cycle, expCycleQ[0]);
          abortRun();
        end
        checkHit(nameQ[0], expHitQ[0], oHit);
        checkData(nameQ[0], expDataQ[0], oData);
        void'(expHitQ.pop_front());
        void'(expDataQ.pop_front());
        void'(expCycleQ.pop_front());
        void'(nameQ.pop_front());
      end
    end else if (expCycleQ.size() != 0 && cycle >= expCycleQ[0]) begin
      $display("oReady for %s never came, expected at cycle %0d", nameQ[0], expCycleQ[0]);
      abortRun();
    end
  end

  initial begin
    logic [tagWidth-1:0]     tagPool [8];
    logic [indexWidth-1:0]   setPool [4];
    logic [2:0]              tagSel;
    logic [1:0]              setSel;
    logic [wordSelWidth-1:0] word;
    bit                      isWr;
    void'($urandom(89709));
    clk      = 1'b0;
    resetn   = 1'b0;
    iRd      = 1'b0;
    iWr      = 1'b0;
    iData    = '0;
    iAddr    = '0;
    cycle    = 0;
    prevBusy = 1'b0;
    for (int s = 0; s < numSets; s++) begin
      for (int w = 0; w < numWays; w++) begin
        refValid[s][w] = 1'b0;
        refAge[s][w]   = age'(w);
      end
    end
    repeat (10) @(posedge clk);
    #1;
    resetn = 1'b1;

    // Idle after reset, then a cold read
    idle(5);
    issue(1'b0, makeAddr(20'h0BEEF, 7'd17, 3'd1), '0, "read after reset");

    issue(1'b1, makeAddr(20'h12345, 7'd5, 3'd2), 32'hCAFE0002, "write miss");
    issue(1'b0, makeAddr(20'h12345, 7'd5, 3'd2), '0, "read written word");
    issue(1'b0, makeAddr(20'h12345, 7'd5, 3'd6), '0, "read unwritten word");
    issue(1'b1, makeAddr(20'h12345, 7'd5, 3'd5), 32'h5555AAAA, "write hit");
    issue(1'b0, makeAddr(20'h12345, 7'd5, 3'd2), '0, "read first word");
    issue(1'b0, makeAddr(20'h12345, 7'd5, 3'd5), '0, "read second word");

    // Five tags into one set force an eviction, then a read hit shifts the next one
    for (int k = 0; k < 5; k++) begin
      issue(1'b1, makeAddr(20'hA0000 + tagWidth'(k), 7'd9, 3'd3), 32'h0F00 + k,
            $sformatf("fill set way %0d", k));
    end
    issue(1'b0, makeAddr(20'hA0000, 7'd9, 3'd3), '0, "read evicted tag");
    issue(1'b0, makeAddr(20'hA0001, 7'd9, 3'd3), '0, "intermediate read hit");
    issue(1'b1, makeAddr(20'hA0005, 7'd9, 3'd3), 32'h0F05, "second eviction");
    for (int k = 0; k < 6; k++) begin
      issue(1'b0, makeAddr(20'hA0000 + tagWidth'(k), 7'd9, 3'd3), '0,
            $sformatf("read back tag %0d", k));
    end

    for (int k = 0; k < 8; k++) begin
      tagPool[k] = tagWidth'(32'h3A5C0 + k * 32'h1011);
    end
    setPool = '{7'd3, 7'd40, 7'd77, 7'd126};
    for (int n = 0; n < numRandom; n++) begin
      tagSel = 3'($urandom());
      setSel = 2'($urandom());
      word   = 3'($urandom());
      isWr   = ($urandom() % 2) == 0;
      issue(isWr, makeAddr(tagPool[tagSel], setPool[setSel], word), $urandom(),
            $sformatf("random %0d", n));
    end

    idle(1);
    while (expCycleQ.size() != 0) begin
      idle(1);
    end
    // A stray pulse here is caught by the checker
    idle(4);
    $display("Test passed");
    $finish;
  end

endmodule

/* files.f */
source/cachePkg.sv
source/wayIf.sv
source/syncRam.sv
source/cacheWay.sv
source/lruAges.sv
source/accessControl.sv
source/cacheTop.sv
dv/cacheTb.sv

/* run.sh */
#!/bin/sh
# Builds the cache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module cacheTb -f files.f -o simCache

./obj_dir/simCache | tee sim.log

if grep -q "Test passed" sim.log; then
  exit 0
fi
echo "Simulation did not report a pass, see sim.log"
exit 1
